// ==== Makefile ====
# Verilator build and run of the synchronous FIFO testbench
TOP := tb_sync_fifo

.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f vlog.f -o $(TOP)
	-./obj_dir/$(TOP) > sim.log 2>&1
	@cat sim.log
	@if grep -q "Test failed" sim.log; then exit 1; fi
	@grep -q "Test passed" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== fifo_assertions.sv ====
// concurrent assertions on fill state and status flags, bound into the level FSM
`timescale 1ns/1ps

module fifo_assertions (
   input logic                      pos_clk,
   input logic                      aresetn,
   input fifo_cfg_pkg::fill_state_e state_i,
   input fifo_sig_pkg::status_t     status_i
);

   // distance between two fill levels
   function automatic int level_step(input logic [2:0] a, input logic [2:0] b);
      int d;
      d = int'(a) - int'(b);
      return (d < 0) ? -d : d;
   endfunction

   //------------------------------------------------------------
   // flag consistency
   //------------------------------------------------------------
   assert property (@(posedge pos_clk) disable iff (!aresetn)
      !(status_i.full && status_i.empty))
      else $error("full and empty both set");

   assert property (@(posedge pos_clk) disable iff (!aresetn)
      status_i.full |-> status_i.afull)
      else $error("full without afull");

   assert property (@(posedge pos_clk) disable iff (!aresetn)
      status_i.empty |-> status_i.aempty)
      else $error("empty without aempty");

   // count moves by one at most, so the level does too
   assert property (@(posedge pos_clk) disable iff (!aresetn)
      level_step(state_i, $past(state_i)) <= 1)
      else $error("fill state jumped more than one level");

endmodule

bind fifo_level_fsm fifo_assertions i_assertions (
   .pos_clk  (pos_clk),
   .aresetn  (aresetn),
   .state_i  (state_q),
   .status_i (status_o)
);

// ==== fifo_cfg_pkg.sv ====
// default FIFO geometry, flag thresholds and fill-level state encoding
package fifo_cfg_pkg;

   //------------------------------------------------------------
   // geometry
   //------------------------------------------------------------

   // payload entries held by the array
   localparam int DEPTH_DEFAULT      = 16;

   // payload width, bits
   localparam int DATA_WIDTH_DEFAULT = 18;

   //------------------------------------------------------------
   // static thresholds
   //------------------------------------------------------------

   // afull once count reaches this value
   localparam int AFULL_DEFAULT      = 12;

   // aempty while count is at or below this value
   localparam int AEMPTY_DEFAULT     = 4;

   //------------------------------------------------------------
   // fill-level states
   //------------------------------------------------------------

   // EMPTY  count == 0
   // LOW    1 .. AEMPTY_LEVEL
   // MID    between the two thresholds
   // HIGH   AFULL_LEVEL .. DEPTH-1
   // FULL   count == DEPTH
   typedef enum logic [2:0] {
      EMPTY = 3'd0,
      LOW   = 3'd1,
      MID   = 3'd2,
      HIGH  = 3'd3,
      FULL  = 3'd4
   } fill_state_e;

endpackage

// ==== fifo_checker.sv ====
// reference queue model that compares the FIFO outputs and counts errors
`timescale 1ns/1ps

module fifo_checker #(
   parameter int DEPTH        = 16,
   parameter int AFULL_LEVEL  = 12,
   parameter int AEMPTY_LEVEL = 4,
   parameter int DATA_W       = 18
) (
   input  logic                         pos_clk,
   input  logic                         aresetn,
   input  logic                         wr_en_i,
   input  logic                         rd_en_i,
   input  logic [DATA_W-1:0]            wr_data_i,
   input  logic [DATA_W-1:0]            rd_data_i,
   input  fifo_sig_pkg::status_t        status_i,
   input  fifo_sig_pkg::event_t         events_i,
   input  logic [$clog2(DEPTH+1)-1:0]   level_i,
   output int                           check_count_o,
   output int                           error_count_o
);

   logic [DATA_W-1:0] model_q [$];   // oldest entry at the front
   logic [DATA_W-1:0] exp_rd_data;   // rd_data_o holds the last read
   logic              exp_wack;
   logic              exp_ovf;
   logic              exp_udf;
   logic              exp_dvld;
   int                checks;
   int                errors;

   assign check_count_o = checks;
   assign error_count_o = errors;

   task automatic compare_bit(input string what, input logic got, input logic exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("ERROR @%0t: %s is %0b, expected %0b", $time, what, got, exp);
      end
   endtask

   task automatic compare_val(input string what, input logic [31:0] got,
                              input logic [31:0] exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("ERROR @%0t: %s is 0x%0h, expected 0x%0h", $time, what, got, exp);
      end
   endtask

   //------------------------------------------------------------
   // outputs against the model, state after the previous edge
   //------------------------------------------------------------
   task automatic check_outputs();
      int n;
      n = model_q.size();
      compare_val("level_o", 32'(level_i), 32'(n));
      compare_bit("full", status_i.full, n == DEPTH);
      compare_bit("afull", status_i.afull, n >= AFULL_LEVEL);
      compare_bit("empty", status_i.empty, n == 0);
      compare_bit("aempty", status_i.aempty, n <= AEMPTY_LEVEL);
      compare_bit("wack", events_i.wack, exp_wack);
      compare_bit("overflow", events_i.overflow, exp_ovf);
      compare_bit("underflow", events_i.underflow, exp_udf);
      compare_bit("dvld", events_i.dvld, exp_dvld);
      compare_val("rd_data_o", 32'(rd_data_i), 32'(exp_rd_data));
   endtask

   // apply this cycle's requests, read before write
   task automatic update_model();
      int   n;
      logic wr_ok;
      logic rd_ok;
      n     = model_q.size();
      wr_ok = wr_en_i && (n < DEPTH);
      rd_ok = rd_en_i && (n > 0);
      exp_wack = wr_ok;
      exp_ovf  = wr_en_i && !wr_ok;
      exp_udf  = rd_en_i && !rd_ok;
      exp_dvld = rd_ok;
      if (rd_ok) begin
         exp_rd_data = model_q.pop_front();
      end
      if (wr_ok) begin
         model_q.push_back(wr_data_i);
      end
   endtask

   initial begin
      checks = 0;
      errors = 0;
   end

   always @(posedge pos_clk) begin
      if (!aresetn) begin
         model_q.delete();
         exp_rd_data = '0;
         exp_wack    = 1'b0;
         exp_ovf     = 1'b0;
         exp_udf     = 1'b0;
         exp_dvld    = 1'b0;
      end else begin
         check_outputs();
         update_model();
      end
   end

endmodule

// ==== fifo_event_flags.sv ====
// registered write acknowledge, overflow, underflow and data-valid pulses
`timescale 1ns/1ps

module fifo_event_flags (
   input  logic                  pos_clk,
   input  logic                  aresetn,
   input  logic                  wr_en_i,
   input  logic                  rd_en_i,
   input  fifo_sig_pkg::xfer_t   xfer_i,
   output fifo_sig_pkg::event_t  events_o
);

   logic wr_drop;   // write requested, not taken
   logic rd_drop;   // read requested, not taken

   // a dropped request is one the FSM refused
   assign wr_drop = wr_en_i && !xfer_i.wr_acc;
   assign rd_drop = rd_en_i && !xfer_i.rd_acc;

   //------------------------------------------------------------
   // one-cycle pulses, each follows its cause by one edge
   //------------------------------------------------------------
   always_ff @(posedge pos_clk or negedge aresetn) begin
      if (!aresetn) begin
         events_o <= '0;
      end else begin
         events_o.wack      <= xfer_i.wr_acc;
         events_o.overflow  <= wr_drop;
         events_o.underflow <= rd_drop;
         events_o.dvld      <= xfer_i.rd_acc;   // lines up with rd_data_o
      end
   end

endmodule

// ==== fifo_level_fsm.sv ====
// fill-level FSM, request qualification and status flag decode
`timescale 1ns/1ps

module fifo_level_fsm #(
   parameter int DEPTH        = 16,
   parameter int AFULL_LEVEL  = 12,
   parameter int AEMPTY_LEVEL = 4
) (
   input  logic                         pos_clk,
   input  logic                         aresetn,
   input  logic                         wr_en_i,
   input  logic                         rd_en_i,
   input  logic [$clog2(DEPTH+1)-1:0]   count_i,
   output fifo_sig_pkg::xfer_t          xfer_o,
   output fifo_sig_pkg::status_t        status_o
);

   localparam int CW = $clog2(DEPTH + 1);

   fifo_cfg_pkg::fill_state_e state_q;
   fifo_cfg_pkg::fill_state_e state_d;

   logic          wr_acc;
   logic          rd_acc;
   logic [CW-1:0] count_nxt;   // count after this edge

   // map a count onto its fill level
   function automatic fifo_cfg_pkg::fill_state_e level_of(input logic [CW-1:0] cnt);
      fifo_cfg_pkg::fill_state_e lvl;
      if (cnt == '0) begin
         lvl = fifo_cfg_pkg::EMPTY;
      end else if (cnt <= CW'(AEMPTY_LEVEL)) begin
         lvl = fifo_cfg_pkg::LOW;
      end else if (cnt < CW'(AFULL_LEVEL)) begin
         lvl = fifo_cfg_pkg::MID;
      end else if (cnt < CW'(DEPTH)) begin
         lvl = fifo_cfg_pkg::HIGH;
      end else begin
         lvl = fifo_cfg_pkg::FULL;
      end
      return lvl;
   endfunction

   //------------------------------------------------------------
   // request qualification
   //------------------------------------------------------------
   assign wr_acc = wr_en_i && (state_q != fifo_cfg_pkg::FULL);
   assign rd_acc = rd_en_i && (state_q != fifo_cfg_pkg::EMPTY);

   assign xfer_o.wr_acc = wr_acc;
   assign xfer_o.rd_acc = rd_acc;

   //------------------------------------------------------------
   // next state
   //------------------------------------------------------------
   always_comb begin
      case ({wr_acc, rd_acc})
         2'b10:   count_nxt = count_i + CW'(1);
         2'b01:   count_nxt = count_i - CW'(1);
         default: count_nxt = count_i;   // idle or both
      endcase
      state_d = level_of(count_nxt);
   end

   always_ff @(posedge pos_clk or negedge aresetn) begin
      if (!aresetn) begin
         state_q <= fifo_cfg_pkg::EMPTY;
      end else begin
         state_q <= state_d;
      end
   end

   //------------------------------------------------------------
   // flags straight from the registered state
   //------------------------------------------------------------
   always_comb begin
      status_o.full   = (state_q == fifo_cfg_pkg::FULL);
      status_o.afull  = (state_q == fifo_cfg_pkg::HIGH) ||
                        (state_q == fifo_cfg_pkg::FULL);
      status_o.empty  = (state_q == fifo_cfg_pkg::EMPTY);
      status_o.aempty = (state_q == fifo_cfg_pkg::EMPTY) ||
                        (state_q == fifo_cfg_pkg::LOW);
   end

endmodule

// ==== fifo_pointer_counter.sv ====
// occupancy counter with wrapping write and read addresses
`timescale 1ns/1ps

module fifo_pointer_counter #(
   parameter int DEPTH = 16
) (
   input  logic                         pos_clk,
   input  logic                         aresetn,
   input  fifo_sig_pkg::xfer_t          xfer_i,
   output logic [$clog2(DEPTH+1)-1:0]   count_o,
   output logic [$clog2(DEPTH)-1:0]     wr_addr_o,
   output logic [$clog2(DEPTH)-1:0]     rd_addr_o
);

   localparam int CW = $clog2(DEPTH + 1);   // 0 .. DEPTH
   localparam int AW = $clog2(DEPTH);       // 0 .. DEPTH-1

   localparam logic [AW-1:0] LAST_ADDR = AW'(DEPTH - 1);

   //------------------------------------------------------------
   // occupancy count
   //------------------------------------------------------------

   // simultaneous read and write leave the count alone
   always_ff @(posedge pos_clk or negedge aresetn) begin
      if (!aresetn) begin
         count_o <= '0;
      end else begin
         case ({xfer_i.wr_acc, xfer_i.rd_acc})
            2'b10:   count_o <= count_o + CW'(1);
            2'b01:   count_o <= count_o - CW'(1);
            default: count_o <= count_o;
         endcase
      end
   end

   //------------------------------------------------------------
   // addresses
   //------------------------------------------------------------

   // explicit wrap, depth need not be a power of two
   always_ff @(posedge pos_clk or negedge aresetn) begin
      if (!aresetn) begin
         wr_addr_o <= '0;
      end else if (xfer_i.wr_acc) begin
         if (wr_addr_o == LAST_ADDR) begin
            wr_addr_o <= '0;
         end else begin
            wr_addr_o <= wr_addr_o + AW'(1);
         end
      end
   end

   always_ff @(posedge pos_clk or negedge aresetn) begin
      if (!aresetn) begin
         rd_addr_o <= '0;
      end else if (xfer_i.rd_acc) begin
         if (rd_addr_o == LAST_ADDR) begin
            rd_addr_o <= '0;
         end else begin
            rd_addr_o <= rd_addr_o + AW'(1);
         end
      end
   end

endmodule

// ==== fifo_sig_pkg.sv ====
// packed structs for accepted transfers, status flags and event pulses
package fifo_sig_pkg;

   //------------------------------------------------------------
   // accepted transfers, combinational from the level FSM
   //------------------------------------------------------------
   typedef struct packed {
      logic wr_acc;   // write taken this cycle
      logic rd_acc;   // read taken this cycle
   } xfer_t;

   //------------------------------------------------------------
   // status flags, decoded from the registered fill state
   //------------------------------------------------------------
   typedef struct packed {
      logic full;
      logic afull;
      logic empty;
      logic aempty;
   } status_t;

   //------------------------------------------------------------
   // one-cycle event pulses
   //------------------------------------------------------------
   typedef struct packed {
      logic wack;       // write acknowledged
      logic overflow;   // write dropped while full
      logic underflow;  // read dropped while empty
      logic dvld;       // rd_data_o valid
   } event_t;

endpackage

// ==== fifo_storage.sv ====
// payload array, synchronous write and registered read
`timescale 1ns/1ps

module fifo_storage #(
   parameter int  DEPTH     = 16,
   parameter type payload_t = logic [fifo_cfg_pkg::DATA_WIDTH_DEFAULT-1:0]
) (
   input  logic                       pos_clk,
   input  logic                       aresetn,
   input  fifo_sig_pkg::xfer_t        xfer_i,
   input  logic [$clog2(DEPTH)-1:0]   wr_addr_i,
   input  logic [$clog2(DEPTH)-1:0]   rd_addr_i,
   input  payload_t                   wr_data_i,
   output payload_t                   rd_data_o
);

   payload_t mem [0:DEPTH-1];

   //------------------------------------------------------------
   // write port
   //------------------------------------------------------------
   always_ff @(posedge pos_clk) begin
      if (xfer_i.wr_acc) begin
         mem[wr_addr_i] <= wr_data_i;
      end
   end

   //------------------------------------------------------------
   // read port, one cycle latency
   //------------------------------------------------------------

   // holds the last entry until the next accepted read
   always_ff @(posedge pos_clk or negedge aresetn) begin
      if (!aresetn) begin
         rd_data_o <= '0;
      end else if (xfer_i.rd_acc) begin
         rd_data_o <= mem[rd_addr_i];
      end
   end

endmodule

// ==== sync_fifo_top.sv ====
// synchronous FIFO top joining FSM, pointer counter, storage and event flags
`timescale 1ns/1ps

module sync_fifo_top #(
   parameter int  DEPTH        = fifo_cfg_pkg::DEPTH_DEFAULT,
   parameter int  AFULL_LEVEL  = fifo_cfg_pkg::AFULL_DEFAULT,
   parameter int  AEMPTY_LEVEL = fifo_cfg_pkg::AEMPTY_DEFAULT,
   parameter type payload_t    = logic [fifo_cfg_pkg::DATA_WIDTH_DEFAULT-1:0]
) (
   input  logic                         pos_clk,
   input  logic                         aresetn,
   input  logic                         wr_en_i,
   input  payload_t                     wr_data_i,
   input  logic                         rd_en_i,
   output payload_t                     rd_data_o,
   output fifo_sig_pkg::status_t        status_o,
   output fifo_sig_pkg::event_t         events_o,
   output logic [$clog2(DEPTH+1)-1:0]   level_o
);

   localparam int AW = $clog2(DEPTH);

   fifo_sig_pkg::xfer_t xfer;
   logic [AW-1:0]       wr_addr;
   logic [AW-1:0]       rd_addr;

   //------------------------------------------------------------
   // control
   //------------------------------------------------------------
   fifo_level_fsm #(
      .DEPTH        (DEPTH),
      .AFULL_LEVEL  (AFULL_LEVEL),
      .AEMPTY_LEVEL (AEMPTY_LEVEL)
   ) i_level_fsm (
      .pos_clk  (pos_clk),
      .aresetn  (aresetn),
      .wr_en_i  (wr_en_i),
      .rd_en_i  (rd_en_i),
      .count_i  (level_o),   // fed back from the counter
      .xfer_o   (xfer),
      .status_o (status_o)
   );

   fifo_pointer_counter #(
      .DEPTH (DEPTH)
   ) i_pointer_counter (
      .pos_clk   (pos_clk),
      .aresetn   (aresetn),
      .xfer_i    (xfer),
      .count_o   (level_o),
      .wr_addr_o (wr_addr),
      .rd_addr_o (rd_addr)
   );

   //------------------------------------------------------------
   // data and events
   //------------------------------------------------------------
   fifo_storage #(
      .DEPTH     (DEPTH),
      .payload_t (payload_t)
   ) i_storage (
      .pos_clk   (pos_clk),
      .aresetn   (aresetn),
      .xfer_i    (xfer),
      .wr_addr_i (wr_addr),
      .rd_addr_i (rd_addr),
      .wr_data_i (wr_data_i),
      .rd_data_o (rd_data_o)
   );

   fifo_event_flags i_event_flags (
      .pos_clk  (pos_clk),
      .aresetn  (aresetn),
      .wr_en_i  (wr_en_i),
      .rd_en_i  (rd_en_i),
      .xfer_i   (xfer),
      .events_o (events_o)
   );

endmodule

// ==== tb_sync_fifo.sv ====
// testbench top: clock, reset, seeded random stimulus, timeout and closing report
`timescale 1ns/1ps

module tb_sync_fifo;

   localparam int DEPTH        = fifo_cfg_pkg::DEPTH_DEFAULT;
   localparam int AFULL_LEVEL  = fifo_cfg_pkg::AFULL_DEFAULT;
   localparam int AEMPTY_LEVEL = fifo_cfg_pkg::AEMPTY_DEFAULT;
   localparam int DATA_W       = fifo_cfg_pkg::DATA_WIDTH_DEFAULT;
   localparam int LW           = $clog2(DEPTH + 1);

   localparam int CLK_HALF     = 4;      // 8 ns period
   localparam int RESET_CYCLES = 4;
   localparam int PHASE_CYCLES = 750;
   localparam int NUM_PHASES   = 4;
   localparam int DRAIN_CYCLES = 20;
   localparam int TEST_CYCLES  = RESET_CYCLES + NUM_PHASES * PHASE_CYCLES + DRAIN_CYCLES;

   // rounded up to the next thousand cycles
   localparam int TIMEOUT_CYCLES = ((TEST_CYCLES + 999) / 1000) * 1000;

   logic                  pos_clk;
   logic                  aresetn;
   logic                  wr_en;
   logic                  rd_en;
   logic [DATA_W-1:0]     wr_data;
   logic [DATA_W-1:0]     rd_data;
   fifo_sig_pkg::status_t status;
   fifo_sig_pkg::event_t  events;
   logic [LW-1:0]         level;

   int          check_count;
   int          error_count;
   int          cycle_count = 0;

   //------------------------------------------------------------
   // DUT and checker
   //------------------------------------------------------------
   sync_fifo_top #(
      .DEPTH        (DEPTH),
      .AFULL_LEVEL  (AFULL_LEVEL),
      .AEMPTY_LEVEL (AEMPTY_LEVEL)
   ) i_dut (
      .pos_clk   (pos_clk),
      .aresetn   (aresetn),
      .wr_en_i   (wr_en),
      .wr_data_i (wr_data),
      .rd_en_i   (rd_en),
      .rd_data_o (rd_data),
      .status_o  (status),
      .events_o  (events),
      .level_o   (level)
   );

   fifo_checker #(
      .DEPTH        (DEPTH),
      .AFULL_LEVEL  (AFULL_LEVEL),
      .AEMPTY_LEVEL (AEMPTY_LEVEL),
      .DATA_W       (DATA_W)
   ) i_checker (
      .pos_clk       (pos_clk),
      .aresetn       (aresetn),
      .wr_en_i       (wr_en),
      .rd_en_i       (rd_en),
      .wr_data_i     (wr_data),
      .rd_data_i     (rd_data),
      .status_i      (status),
      .events_i      (events),
      .level_i       (level),
      .check_count_o (check_count),
      .error_count_o (error_count)
   );

   initial begin
      pos_clk = 1'b0;
      forever #CLK_HALF pos_clk = ~pos_clk;
   end

   // random requests, new values on each falling edge
   task automatic drive_random(input int cycles, input int wr_pct, input int rd_pct);
      for (int i = 0; i < cycles; i++) begin
         @(negedge pos_clk);
         wr_en   = ($urandom % 100) < wr_pct;
         rd_en   = ($urandom % 100) < rd_pct;
         wr_data = DATA_W'($urandom);
      end
   endtask

   //------------------------------------------------------------
   // main sequence
   //------------------------------------------------------------
   initial begin
      aresetn  = 1'b0;
      wr_en    = 1'b0;
      rd_en    = 1'b0;
      wr_data  = DATA_W'($urandom(32'hd4d9));   // seeds the generator once
      repeat (RESET_CYCLES) @(posedge pos_clk);
      @(negedge pos_clk);
      aresetn = 1'b1;

      drive_random(PHASE_CYCLES, 80, 30);        // fill up, hit overflow
      drive_random(PHASE_CYCLES, 50, 50);
      drive_random(PHASE_CYCLES, 25, 80);        // drain, hit underflow
      drive_random(PHASE_CYCLES / 2, 85, 20);
      drive_random(PHASE_CYCLES - PHASE_CYCLES / 2, 20, 85);
      drive_random(DRAIN_CYCLES, 0, 0);          // idle, last pulses settle
      @(negedge pos_clk);

      $display("checks %0d, errors %0d", check_count, error_count);
      if (error_count == 0) begin
         $display("Test passed");
      end else begin
         $display("Test failed");
      end
      $finish;
   end

   // guard against a hung run
   always @(posedge pos_clk) begin
      cycle_count++;
      if (cycle_count >= TIMEOUT_CYCLES) begin
         $display("timeout after %0d cycles, stimulus never finished", cycle_count);
         $display("Test failed");
         $finish;
      end
   end

endmodule

// ==== vlog.f ====
fifo_cfg_pkg.sv
fifo_sig_pkg.sv
fifo_pointer_counter.sv
fifo_level_fsm.sv
fifo_event_flags.sv
fifo_storage.sv
sync_fifo_top.sv
fifo_assertions.sv
fifo_checker.sv
tb_sync_fifo.sv
